/* hdl/data_sram.sv */
`timescale 1ns/1ps

module data_sram (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                head_valid_i,
    input  lsu_pkg::cache_req_t head_i,
    output logic                pop_o,
    output lsu_pkg::cache_rsp_t rsp_o
);

    logic [lsu_pkg::XLEN-1:0] ram [lsu_pkg::RAM_WORDS];

    logic [lsu_pkg::RAM_AW-1:0] idx;
    logic [lsu_pkg::XLEN-1:0] rdata_q;
    logic data_ok_q;
    logic rd_en;

    // Word index from address bits 9:2
    assign idx = head_i.addr[lsu_pkg::RAM_AW+1:2];

    // One entry served every cycle
    assign pop_o = head_valid_i;
    assign rd_en = head_valid_i && !head_i.we;

    always_ff @(posedge clk) begin
        if (head_valid_i && head_i.we) begin
            for (int i = 0; i < lsu_pkg::BYTES; i++) begin
                if (head_i.sel[i]) begin
                    ram[idx][i*8 +: 8] <= head_i.data[i*8 +: 8];
                end
            end
        end
    end

    // Whole word comes back, the stage picks lanes
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= ram[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= rd_en;
        end
    end

    assign rsp_o.data_ok = data_ok_q;
    assign rsp_o.rdata = rdata_q;

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // Datapath and sizing
    localparam int XLEN        = 32;
    localparam int BYTES       = XLEN / 8;
    localparam int RAM_WORDS   = 256;
    localparam int RAM_AW      = $clog2(RAM_WORDS);
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PW    = $clog2(QUEUE_DEPTH);

    // Memory operation codes from execute
    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } mem_op_e;

    // Execute to memory stage
    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        logic [XLEN-1:0] mem_addr;
        logic [XLEN-1:0] reg2;
        logic [4:0]      waddr;
        logic            wreg;
    } ex_mem_t;

    // One cache request, store data already replicated over the lanes
    typedef struct packed {
        logic            we;
        logic [3:0]      sel;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } cache_req_t;

    typedef struct packed {
        logic            data_ok;
        logic [XLEN-1:0] rdata;
    } cache_rsp_t;

    // Write-back record, with the link bit update
    typedef struct packed {
        logic            valid;
        logic            wreg;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
        mem_op_e         op;
        logic            is_ll_set;
        logic            is_ll_clear;
    } mem_wb_t;

    // Forwarding to dispatch and execute
    typedef struct packed {
        logic            is_load;
        logic            wreg;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
    } mem_fwd_t;

endpackage

/* hdl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  lsu_pkg::ex_mem_t    ex_i,
    input  logic                llbit_i,
    input  logic                addr_ok_i,
    input  lsu_pkg::cache_rsp_t rsp_i,
    output logic                push_o,
    output lsu_pkg::cache_req_t req_o,
    output logic                stall_o,
    output lsu_pkg::mem_wb_t    wb_o,
    output lsu_pkg::mem_fwd_t   fwd_o
);

    logic is_load;
    logic is_store;
    logic is_sc;
    logic is_half;
    logic misaligned;
    logic sc_ok;
    logic need_req;
    logic need_rsp;
    logic issued_q;
    logic waiting;
    logic accept;
    logic complete;
    logic wreg_c;
    logic [7:0] lane_b;
    logic [15:0] lane_h;
    logic [lsu_pkg::XLEN-1:0] wdata_c;

    // Operation classes
    assign is_load = ex_i.op inside {lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_LD_H,
                                     lsu_pkg::OP_LD_HU, lsu_pkg::OP_LD_W, lsu_pkg::OP_LL};
    assign is_store = ex_i.op inside {lsu_pkg::OP_ST_B, lsu_pkg::OP_ST_H, lsu_pkg::OP_ST_W};
    assign is_sc = ex_i.op == lsu_pkg::OP_SC;
    assign is_half = ex_i.op inside {lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_HU, lsu_pkg::OP_ST_H};

    // Odd halfword goes nowhere
    assign misaligned = is_half && ex_i.mem_addr[0];
    assign sc_ok = is_sc && llbit_i;

    assign need_req = ex_i.valid && !misaligned && (is_load || is_store || sc_ok);
    assign need_rsp = need_req && is_load;

    assign push_o = need_req && !issued_q;
    assign accept = push_o && addr_ok_i;
    assign waiting = issued_q && need_rsp;

    // Stores are posted, loads wait for data_ok
    assign complete = ex_i.valid && (!need_req || (accept && !need_rsp) ||
                                     (waiting && rsp_i.data_ok));
    assign stall_o = ex_i.valid && !complete;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issued_q <= 1'b0;
        end else if (complete) begin
            issued_q <= 1'b0;
        end else if (accept) begin
            issued_q <= 1'b1;
        end
    end

    // Request lanes and store data
    always_comb begin
        req_o = '0;
        req_o.we = is_store || is_sc;
        req_o.addr = ex_i.mem_addr;
        case (ex_i.op)
            lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_ST_B: begin
                req_o.sel = 4'b0001 << ex_i.mem_addr[1:0];
            end
            lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_HU, lsu_pkg::OP_ST_H: begin
                req_o.sel = ex_i.mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                req_o.sel = 4'b1111;
            end
        endcase
        case (ex_i.op)
            lsu_pkg::OP_ST_B: begin
                req_o.data = {4{ex_i.reg2[7:0]}};
            end
            lsu_pkg::OP_ST_H: begin
                req_o.data = {2{ex_i.reg2[15:0]}};
            end
            lsu_pkg::OP_ST_W, lsu_pkg::OP_SC: begin
                req_o.data = ex_i.reg2;
            end
            default: begin
                req_o.data = '0;
            end
        endcase
    end

    // Pick the addressed lanes of the returned word
    assign lane_b = rsp_i.rdata[{ex_i.mem_addr[1:0], 3'b000} +: 8];
    assign lane_h = ex_i.mem_addr[1] ? rsp_i.rdata[31:16] : rsp_i.rdata[15:0];

    always_comb begin
        wdata_c = '0;
        case (ex_i.op)
            lsu_pkg::OP_LD_B: begin
                wdata_c = {{(lsu_pkg::XLEN-8){lane_b[7]}}, lane_b};
            end
            lsu_pkg::OP_LD_BU: begin
                wdata_c = {{(lsu_pkg::XLEN-8){1'b0}}, lane_b};
            end
            lsu_pkg::OP_LD_H: begin
                if (!misaligned) begin
                    wdata_c = {{(lsu_pkg::XLEN-16){lane_h[15]}}, lane_h};
                end
            end
            lsu_pkg::OP_LD_HU: begin
                if (!misaligned) begin
                    wdata_c = {{(lsu_pkg::XLEN-16){1'b0}}, lane_h};
                end
            end
            lsu_pkg::OP_LD_W, lsu_pkg::OP_LL: begin
                wdata_c = rsp_i.rdata;
            end
            lsu_pkg::OP_SC: begin
                // 1 on success, 0 on failure
                wdata_c = {{(lsu_pkg::XLEN-1){1'b0}}, sc_ok};
            end
            default: begin
                wdata_c = '0;
            end
        endcase
    end

    // Only loads and SC write a register
    assign wreg_c = ex_i.wreg && (is_load || is_sc);

    always_comb begin
        wb_o.valid = complete;
        wb_o.wreg = wreg_c;
        wb_o.waddr = ex_i.waddr;
        wb_o.wdata = wdata_c;
        wb_o.op = ex_i.op;
        wb_o.is_ll_set = complete && ex_i.op == lsu_pkg::OP_LL;
        wb_o.is_ll_clear = complete && sc_ok;
    end

    always_comb begin
        fwd_o.is_load = ex_i.valid && is_load;
        fwd_o.wreg = ex_i.valid && wreg_c;
        fwd_o.waddr = ex_i.waddr;
        fwd_o.wdata = wdata_c;
    end

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  lsu_pkg::ex_mem_t  ex_i,
    output logic              stall_o,
    output lsu_pkg::mem_wb_t  wb_o,
    output lsu_pkg::mem_fwd_t fwd_o
);

    logic push;
    logic addr_ok;
    logic pop;
    logic head_valid;
    logic llbit;
    lsu_pkg::cache_req_t req;
    lsu_pkg::cache_req_t head;
    lsu_pkg::cache_rsp_t rsp;
    lsu_pkg::mem_wb_t stage_wb;

    mem_stage u_stage (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ex_i      (ex_i),
        .llbit_i   (llbit),
        .addr_ok_i (addr_ok),
        .rsp_i     (rsp),
        .push_o    (push),
        .req_o     (req),
        .stall_o   (stall_o),
        .wb_o      (stage_wb),
        .fwd_o     (fwd_o)
    );

    req_queue u_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .req_i        (req),
        .addr_ok_o    (addr_ok),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head)
    );

    data_sram u_sram (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .rsp_o        (rsp)
    );

    wb_stage u_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (stage_wb),
        .wb_o    (wb_o),
        .llbit_o (llbit)
    );

endmodule

/* hdl/req_queue.sv */
`timescale 1ns/1ps

module req_queue (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                push_i,
    input  lsu_pkg::cache_req_t req_i,
    output logic                addr_ok_o,
    input  logic                pop_i,
    output logic                head_valid_o,
    output lsu_pkg::cache_req_t head_o
);

    lsu_pkg::cache_req_t entries [lsu_pkg::QUEUE_DEPTH];

    logic [lsu_pkg::QUEUE_PW-1:0] wr_ptr;
    logic [lsu_pkg::QUEUE_PW-1:0] rd_ptr;
    logic [lsu_pkg::QUEUE_PW:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = count == (lsu_pkg::QUEUE_PW + 1)'(lsu_pkg::QUEUE_DEPTH);
    assign head_valid_o = count != '0;
    assign head_o = entries[rd_ptr];

    // A pop in the same cycle frees a slot for the push
    assign addr_ok_o = !full || pop_i;
    assign do_push = push_i && addr_ok_o;
    assign do_pop = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  lsu_pkg::mem_wb_t wb_i,
    output lsu_pkg::mem_wb_t wb_o,
    output logic             llbit_o
);

    lsu_pkg::mem_wb_t wb_q;
    logic llbit_q;
    logic ll_we;
    logic ll_value;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_i;
        end
    end

    // Link bit written from the committed record
    assign ll_we = wb_q.valid && (wb_q.is_ll_set || wb_q.is_ll_clear);
    assign ll_value = wb_q.is_ll_set;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_q <= 1'b0;
        end else if (ll_we) begin
            llbit_q <= ll_value;
        end
    end

    // Bypass so an SC right behind LL sees the new value
    assign llbit_o = ll_we ? ll_value : llbit_q;
    assign wb_o = wb_q;

endmodule

/* mem_subsys.f */
hdl/lsu_pkg.sv
hdl/data_sram.sv
hdl/req_queue.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/mem_subsys_top.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

/* tests/mem_subsys_sva.sv */
`timescale 1ns/1ps

module mem_subsys_sva (
    input logic             clk,
    input logic             rst_n_i,
    input lsu_pkg::ex_mem_t ex_i,
    input logic             stall_i,
    input logic             push_i,
    input logic             addr_ok_i,
    input logic             pop_i,
    input logic             head_valid_i,
    input logic             data_ok_i,
    input logic             done_i,
    input logic             wb_valid_i
);

    int fail_count = 0;
    int occupancy;
    logic load_op;

    assign load_op = ex_i.op inside {lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_LD_H,
                                     lsu_pkg::OP_LD_HU, lsu_pkg::OP_LD_W, lsu_pkg::OP_LL};

    // Queue fill level rebuilt from the handshakes
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push_i && addr_ok_i) - int'(pop_i && head_valid_i);
        end
    end

    stall_known: assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(stall_i))
        else begin
            fail_count++;
            $error("stall_o is unknown after reset");
        end

    data_ok_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        data_ok_i |-> (ex_i.valid && load_op))
        else begin
            fail_count++;
            $error("data_ok high with no load waiting");
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        (push_i && addr_ok_i) |-> (occupancy < lsu_pkg::QUEUE_DEPTH || pop_i))
        else begin
            fail_count++;
            $error("push accepted into a full queue without a pop");
        end

    wb_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i == $past(done_i))
        else begin
            fail_count++;
            $error("wb_o.valid does not follow completion by one cycle");
        end

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ex_i         (ex_i),
    .stall_i      (stall_o),
    .push_i       (push),
    .addr_ok_i    (addr_ok),
    .pop_i        (pop),
    .head_valid_i (head_valid),
    .data_ok_i    (rsp.data_ok),
    .done_i       (ex_i.valid && !stall_o),
    .wb_valid_i   (wb_o.valid)
);

/* tests/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int MAX_CYCLES = 3000;

    typedef struct packed {
        logic        writes;
        logic [31:0] wdata;
        logic        ll_set;
        logic        ll_clear;
    } ref_t;

    typedef struct packed {
        logic             wreg;
        logic [4:0]       waddr;
        logic [31:0]      wdata;
        lsu_pkg::mem_op_e op;
        logic             ll_set;
        logic             ll_clear;
    } wb_exp_t;

    logic clk;
    logic rst_n;
    logic stall;
    lsu_pkg::ex_mem_t ex;
    lsu_pkg::mem_wb_t wb;
    lsu_pkg::mem_fwd_t fwd;

    logic [31:0] model_mem [lsu_pkg::RAM_WORDS];
    logic model_ll;
    wb_exp_t exp_q [$];
    string name_q [$];
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    mem_subsys_top DUT (
        .clk     (clk),
        .rst_n_i (rst_n),
        .ex_i    (ex),
        .stall_o (stall),
        .wb_o    (wb),
        .fwd_o   (fwd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Expected write-back per the load/store rules
    function automatic ref_t ref_result(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                                        input logic [31:0] word, input logic ll);
        ref_t r;
        logic [7:0] b;
        logic [15:0] h;
        r = '0;
        b = word[8*int'(addr[1:0]) +: 8];
        h = addr[1] ? word[31:16] : word[15:0];
        case (op)
            lsu_pkg::OP_LD_B:  r.wdata = {{24{b[7]}}, b};
            lsu_pkg::OP_LD_BU: r.wdata = {24'd0, b};
            lsu_pkg::OP_LD_H:  r.wdata = addr[0] ? 32'd0 : {{16{h[15]}}, h};
            lsu_pkg::OP_LD_HU: r.wdata = addr[0] ? 32'd0 : {16'd0, h};
            lsu_pkg::OP_LD_W:  r.wdata = word;
            lsu_pkg::OP_LL: begin
                r.wdata = word;
                r.ll_set = 1'b1;
            end
            lsu_pkg::OP_SC: begin
                r.wdata = {31'd0, ll};
                r.ll_clear = ll;
            end
            default: r.wdata = 32'd0;
        endcase
        r.writes = op inside {lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_LD_H,
                              lsu_pkg::OP_LD_HU, lsu_pkg::OP_LD_W, lsu_pkg::OP_LL,
                              lsu_pkg::OP_SC};
        return r;
    endfunction

    function automatic logic [31:0] store_merge(input lsu_pkg::mem_op_e op,
                                                input logic [31:0] addr, input logic [31:0] reg2,
                                                input logic [31:0] word, input logic ll);
        logic [31:0] w;
        w = word;
        case (op)
            lsu_pkg::OP_ST_B: w[8*int'(addr[1:0]) +: 8] = reg2[7:0];
            lsu_pkg::OP_ST_H: if (!addr[0]) w[16*int'(addr[1]) +: 16] = reg2[15:0];
            lsu_pkg::OP_ST_W: w = reg2;
            lsu_pkg::OP_SC:   if (ll) w = reg2;
            default: w = word;
        endcase
        return w;
    endfunction

    // Present one operation and hold it until it completes
    task automatic run_op(input string name, input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] reg2, input logic [4:0] waddr, input logic wreg);
        ref_t r;
        logic [7:0] idx;
        logic no_req;
        logic exp_load;
        idx = addr[9:2];
        r = ref_result(op, addr, model_mem[idx], model_ll);
        exp_q.push_back({wreg && r.writes, waddr, r.wdata, op, r.ll_set, r.ll_clear});
        name_q.push_back(name);
        no_req = op == lsu_pkg::OP_NONE || (op == lsu_pkg::OP_SC && !model_ll) ||
                 (op inside {lsu_pkg::OP_LD_H, lsu_pkg::OP_LD_HU, lsu_pkg::OP_ST_H} && addr[0]);
        exp_load = op inside {lsu_pkg::OP_LD_B, lsu_pkg::OP_LD_BU, lsu_pkg::OP_LD_H,
                              lsu_pkg::OP_LD_HU, lsu_pkg::OP_LD_W, lsu_pkg::OP_LL};
        model_mem[idx] = store_merge(op, addr, reg2, model_mem[idx], model_ll);
        if (r.ll_set) model_ll = 1'b1;
        if (r.ll_clear) model_ll = 1'b0;
        ex.valid = 1'b1;
        ex.op = op;
        ex.mem_addr = addr;
        ex.reg2 = reg2;
        ex.waddr = waddr;
        ex.wreg = wreg;
        @(negedge clk);
        if (no_req && stall) begin
            errors++;
            $display("%s: stall_o went high for an operation that sends no request", name);
        end
        while (stall) @(negedge clk);
        // Forwarding record in the completion cycle
        checks++;
        if (fwd.is_load !== exp_load || fwd.wreg !== (wreg && r.writes) ||
            fwd.waddr !== waddr || fwd.wdata !== r.wdata) begin
            errors++;
            $display("CHECK FAILED %s fwd: expected %b %b %0d %h actual %b %b %0d %h", name,
                     exp_load, wreg && r.writes, waddr, r.wdata,
                     fwd.is_load, fwd.wreg, fwd.waddr, fwd.wdata);
        end
        @(posedge clk);
        #1;
        ex.valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_mix();
        lsu_pkg::mem_op_e op;
        logic [31:0] addr;
        // Fill the 64-word window first
        for (int i = 0; i < 64; i++) begin
            run_op("fill", lsu_pkg::OP_ST_W, 32'h100 + 32'(i * 4), $urandom, 5'd0, 1'b1);
        end
        for (int i = 0; i < 200; i++) begin
            op = lsu_pkg::mem_op_e'(4'($urandom % 11));
            addr = 32'h100 + (($urandom % 64) << 2) + ($urandom % 4);
            run_op("random", op, addr, $urandom, 5'($urandom % 32), 1'($urandom % 2));
            idle_cycles(int'($urandom % 3));
        end
    endtask

    initial begin : compare_wb
        wb_exp_t exp;
        string name;
        forever begin
            @(negedge clk);
            if (rst_n && wb.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Write-back to register %0d arrived with nothing expected", wb.waddr);
                end else begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    checks++;
                    if (wb.wreg !== exp.wreg) begin
                        errors++;
                        $display("CHECK FAILED %s wreg: expected %b actual %b", name, exp.wreg,
                                 wb.wreg);
                    end
                    if (wb.waddr !== exp.waddr) begin
                        errors++;
                        $display("CHECK FAILED %s waddr: expected %0d actual %0d", name,
                                 exp.waddr, wb.waddr);
                    end
                    if (wb.wdata !== exp.wdata) begin
                        errors++;
                        $display("CHECK FAILED %s wdata: expected %h actual %h", name,
                                 exp.wdata, wb.wdata);
                    end
                    if (wb.op !== exp.op) begin
                        errors++;
                        $display("CHECK FAILED %s op: expected %0d actual %0d", name,
                                 exp.op, wb.op);
                    end
                    if (wb.is_ll_set !== exp.ll_set || wb.is_ll_clear !== exp.ll_clear) begin
                        errors++;
                        $display("CHECK FAILED %s link set/clear: expected %b%b actual %b%b",
                                 name, exp.ll_set, exp.ll_clear, wb.is_ll_set,
                                 wb.is_ll_clear);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hf8731df9));
        model_ll = 1'b0;
        rst_n = 1'b0;
        ex = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_op("word_rw", lsu_pkg::OP_ST_W, 32'h10, 32'hdead_beef, 5'd1, 1'b0);
        run_op("word_rw", lsu_pkg::OP_LD_W, 32'h10, 32'd0, 5'd2, 1'b1);
        for (int i = 0; i < 6; i++) begin
            run_op("store_order", lsu_pkg::OP_ST_W, 32'h20 + 32'(i * 4), $urandom, 5'd0, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            run_op("store_order", lsu_pkg::OP_LD_W, 32'h20 + 32'(i * 4), 32'd0, 5'(i), 1'b1);
        end

        // Partial stores touch only their lanes
        run_op("lane_store", lsu_pkg::OP_ST_W, 32'h40, 32'h0102_0304, 5'd0, 1'b0);
        run_op("lane_store", lsu_pkg::OP_ST_W, 32'h44, 32'h0506_0708, 5'd0, 1'b0);
        for (int off = 0; off < 4; off++) begin
            run_op("lane_store", lsu_pkg::OP_ST_B, 32'h40 + 32'(off), $urandom, 5'd0, 1'b0);
            run_op("lane_store", lsu_pkg::OP_LD_W, 32'h40, 32'd0, 5'd3, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_op("lane_store", lsu_pkg::OP_ST_H, 32'h44 + 32'(off), $urandom, 5'd0, 1'b0);
            run_op("lane_store", lsu_pkg::OP_LD_W, 32'h44, 32'd0, 5'd4, 1'b1);
        end

        run_op("extend", lsu_pkg::OP_ST_W, 32'h48, 32'h80f1_7f8e, 5'd0, 1'b0);
        for (int off = 0; off < 4; off++) begin
            run_op("extend", lsu_pkg::OP_LD_B, 32'h48 + 32'(off), 32'd0, 5'd5, 1'b1);
            run_op("extend", lsu_pkg::OP_LD_BU, 32'h48 + 32'(off), 32'd0, 5'd6, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_op("extend", lsu_pkg::OP_LD_H, 32'h48 + 32'(off), 32'd0, 5'd7, 1'b1);
            run_op("extend", lsu_pkg::OP_LD_HU, 32'h48 + 32'(off), 32'd0, 5'd8, 1'b1);
        end

        run_op("misaligned", lsu_pkg::OP_ST_W, 32'h4c, 32'h1234_5678, 5'd0, 1'b0);
        run_op("misaligned", lsu_pkg::OP_LD_H, 32'h4d, 32'd0, 5'd9, 1'b1);
        run_op("misaligned", lsu_pkg::OP_LD_HU, 32'h4f, 32'd0, 5'd10, 1'b1);
        run_op("misaligned", lsu_pkg::OP_ST_H, 32'h4d, 32'hffff_ffff, 5'd0, 1'b0);
        run_op("misaligned", lsu_pkg::OP_LD_W, 32'h4c, 32'd0, 5'd11, 1'b1);

        run_op("sc_no_ll", lsu_pkg::OP_ST_W, 32'h50, 32'h1111_1111, 5'd0, 1'b0);
        run_op("sc_no_ll", lsu_pkg::OP_SC, 32'h50, 32'h2222_2222, 5'd12, 1'b1);
        run_op("sc_no_ll", lsu_pkg::OP_LD_W, 32'h50, 32'd0, 5'd13, 1'b1);
        run_op("ll_sc", lsu_pkg::OP_LL, 32'h50, 32'd0, 5'd14, 1'b1);
        run_op("ll_sc", lsu_pkg::OP_SC, 32'h50, 32'h3333_3333, 5'd15, 1'b1);
        run_op("ll_sc", lsu_pkg::OP_LD_W, 32'h50, 32'd0, 5'd16, 1'b1);
        run_op("sc_again", lsu_pkg::OP_SC, 32'h50, 32'h4444_4444, 5'd17, 1'b1);
        run_op("sc_again", lsu_pkg::OP_LD_W, 32'h50, 32'd0, 5'd18, 1'b1);

        random_mix();

        idle_cycles(4);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected write-backs never arrived", exp_q.size());
        end
        errors += DUT.u_sva.fail_count;
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
